// ==== Makefile ====
TOOL      ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_quad_bram_ctrl
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
rtl/quad_ctrl_pkg.sv
rtl/row_fetch_if.sv
rtl/window_pass_if.sv
rtl/job_ctrl_fsm.sv
rtl/pfb_row_reader.sv
rtl/pix_seq_reader.sv
rtl/ce_issue_chain.sv
rtl/quad_bram_ctrl.sv
dv/tb_quad_bram_ctrl.sv

// ==== dv/tb_quad_bram_ctrl.sv ====
module tb_quad_bram_ctrl;
    import quad_ctrl_pkg::*;

    localparam int NUM_JOBS = 4;

    logic        clk;
    logic        rst;
    row_col_t    num_expd_input_cols;
    row_col_t    num_expd_input_rows;
    row_col_t    num_output_cols;
    pfb_count_t  pfb_full_count;
    seq_addr_t   pix_seq_data_full_count;
    kernel_grp_t num_kernels;
    logic        job_start;
    logic        job_accept;
    logic        job_fetch_request;
    logic        job_fetch_in_progress;
    logic        job_fetch_ack;
    logic        job_fetch_complete;
    logic        job_complete;
    logic        job_complete_ack;
    logic        pipeline_flushed;
    logic        pfb_rden;
    row_col_t    input_col;
    logic        pix_seq_bram_rden;
    seq_addr_t   pix_seq_bram_rdaddr;
    win_cyc_t    cycle_counter;
    gray_t       gray_code;
    ce_vec_t     ce_execute;
    ce_vec_t     next_kernel;
    logic        ctrl_last_kernel;

    quad_bram_ctrl uut (.*);

    logic [31:0] lcg_state = 32'h61be_ac2d;
    int          cycle_limit = 1000;
    int          cycles = 0;
    bit          failed = 0;

    // Model state
    int          run_len;
    int          fetch_cnt;
    int          seq_idx;
    int          win_cnt;
    int          passes_done;
    logic        rden_q;
    logic        inprog_model;
    kernel_grp_t grp_model;
    kernel_grp_t grp_next;
    logic        last_exp;
    logic        win_end_model;
    logic        final_window;

    // Delayed copies for the chain checks
    logic [SEQ_RD_LATENCY-1:0] rden_hist;
    ce_vec_t                   exec_q;
    ce_vec_t                   nk_q;
    logic                      final_q;

    int job_rows [NUM_JOBS];
    int job_pfb  [NUM_JOBS];
    int job_seq  [NUM_JOBS];
    int job_cols [NUM_JOBS];
    int job_nk   [NUM_JOBS];

    function automatic int rand_range(int lo, int hi);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lo + int'(lcg_state[31:16]) % (hi - lo + 1);
    endfunction

    function automatic gray_t to_gray(int n);
        logic [1:0] b;
        b = n[1:0];
        return b ^ (b >> 1);
    endfunction

    task automatic report_mismatch(string name, int exp, int act);
        failed = 1;
        $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic report_error(string msg);
        failed = 1;
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic wait_cycles(int n);
        repeat (n) @(negedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////
    // Reference model, updated on the rising edge
    ////////////////////////////////////////////////////////////////////

    assign win_end_model = pix_seq_bram_rden && (seq_idx % WINDOW_CYCLES == WINDOW_CYCLES - 1);
    assign final_window  = win_end_model
                         && (win_cnt % int'(num_output_cols) == int'(num_output_cols) - 1);
    assign grp_next      = !win_end_model ? grp_model
                         : (grp_model == num_kernels) ? '0 : grp_model + 1'b1;

    always @(posedge clk) begin
        if (rst) begin
            run_len      <= 0;
            fetch_cnt    <= 0;
            seq_idx      <= 0;
            win_cnt      <= 0;
            passes_done  <= 0;
            rden_q       <= 1'b0;
            inprog_model <= 1'b0;
            grp_model    <= '0;
            last_exp     <= 1'b0;
            rden_hist    <= '0;
            exec_q       <= '0;
            nk_q         <= '0;
            final_q      <= 1'b0;
        end else begin
            run_len   <= pfb_rden ? run_len + 1 : 0;
            seq_idx   <= pix_seq_bram_rden ? seq_idx + 1 : 0;
            if (!pix_seq_bram_rden) begin
                win_cnt <= 0;
            end else if (win_end_model) begin
                win_cnt <= win_cnt + 1;
            end
            if (job_accept) begin
                fetch_cnt <= 0;
            end else if (job_fetch_request && job_fetch_ack) begin
                fetch_cnt <= fetch_cnt + 1;
            end
            // Fetch in progress from the ack until the complete
            if (job_fetch_request && job_fetch_ack) begin
                inprog_model <= 1'b1;
            end else if (job_fetch_complete && inprog_model) begin
                inprog_model <= 1'b0;
            end
            if (rden_q && !pix_seq_bram_rden) begin
                passes_done <= passes_done + 1;
            end
            rden_q    <= pix_seq_bram_rden;
            grp_model <= grp_next;
            last_exp  <= (grp_next == num_kernels);
            rden_hist <= {rden_hist[SEQ_RD_LATENCY-2:0], pix_seq_bram_rden};
            exec_q    <= ce_execute;
            nk_q      <= next_kernel;
            final_q   <= final_window;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////

    a_accept: assert property (@(posedge clk) disable iff (rst)
        job_accept |-> $past(job_start) ##1 !job_accept)
        else report_error("job_accept without job_start or longer than one cycle");
    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        job_fetch_request && !job_fetch_ack |=> job_fetch_request)
        else report_error("job_fetch_request dropped before the ack");
    a_req_drop: assert property (@(posedge clk) disable iff (rst)
        job_fetch_request && job_fetch_ack |=> !job_fetch_request)
        else report_error("job_fetch_request stayed high after the ack");
    a_in_progress: assert property (@(posedge clk) disable iff (rst)
        job_fetch_in_progress == inprog_model)
        else report_mismatch("fetch_in_progress", $sampled(inprog_model),
                             $sampled(job_fetch_in_progress));
    a_cpl_hold: assert property (@(posedge clk) disable iff (rst)
        job_complete && !job_complete_ack |=> job_complete)
        else report_error("job_complete dropped before the ack");
    a_cpl_drop: assert property (@(posedge clk) disable iff (rst)
        job_complete && job_complete_ack |=> !job_complete)
        else report_error("job_complete stayed high after the ack");
    a_pfb_burst: assert property (@(posedge clk) disable iff (rst)
        $fell(pfb_rden) |-> run_len == int'(pfb_full_count))
        else report_mismatch("pfb_burst", int'(pfb_full_count), $sampled(run_len));
    a_input_col: assert property (@(posedge clk) disable iff (rst)
        pfb_rden |-> int'(input_col) == run_len)
        else report_mismatch("input_col", $sampled(run_len), $sampled(input_col));
    a_fetch_cnt: assert property (@(posedge clk) disable iff (rst)
        $rose(job_complete) |-> fetch_cnt == int'(num_expd_input_rows) + 1)
        else report_mismatch("fetch_count", int'(num_expd_input_rows) + 1,
                             $sampled(fetch_cnt));
    a_seq_burst: assert property (@(posedge clk) disable iff (rst)
        $fell(pix_seq_bram_rden) |-> seq_idx == int'(pix_seq_data_full_count))
        else report_mismatch("seq_burst", int'(pix_seq_data_full_count), $sampled(seq_idx));
    a_seq_addr: assert property (@(posedge clk) disable iff (rst)
        pix_seq_bram_rden |-> int'(pix_seq_bram_rdaddr) == seq_idx)
        else report_mismatch("seq_addr", $sampled(seq_idx), $sampled(pix_seq_bram_rdaddr));
    a_win_idx: assert property (@(posedge clk) disable iff (rst)
        pix_seq_bram_rden |-> int'(cycle_counter) == seq_idx % WINDOW_CYCLES)
        else report_mismatch("window_index", $sampled(seq_idx) % WINDOW_CYCLES,
                             $sampled(cycle_counter));
    a_gray: assert property (@(posedge clk) disable iff (rst)
        pix_seq_bram_rden |-> gray_code == to_gray(passes_done))
        else report_mismatch("gray_code", to_gray($sampled(passes_done)),
                             $sampled(gray_code));
    a_exec0: assert property (@(posedge clk) disable iff (rst)
        ce_execute[0] == rden_hist[SEQ_RD_LATENCY-1])
        else report_mismatch("ce_execute0", $sampled(rden_hist[SEQ_RD_LATENCY-1]),
                             $sampled(ce_execute[0]));
    a_exec_chain: assert property (@(posedge clk) disable iff (rst)
        ce_execute[NUM_CE-1:1] == exec_q[NUM_CE-2:0])
        else report_mismatch("ce_execute_chain", $sampled(exec_q[NUM_CE-2:0]),
                             $sampled(ce_execute[NUM_CE-1:1]));
    a_nk0: assert property (@(posedge clk) disable iff (rst)
        next_kernel[0] == final_q)
        else report_mismatch("next_kernel0", $sampled(final_q), $sampled(next_kernel[0]));
    a_nk_chain: assert property (@(posedge clk) disable iff (rst)
        next_kernel[NUM_CE-1:1] == nk_q[NUM_CE-2:0])
        else report_mismatch("next_kernel_chain", $sampled(nk_q[NUM_CE-2:0]),
                             $sampled(next_kernel[NUM_CE-1:1]));
    a_last_kernel: assert property (@(posedge clk) disable iff (rst)
        ctrl_last_kernel == last_exp)
        else report_mismatch("last_kernel", $sampled(last_exp), $sampled(ctrl_last_kernel));

    ////////////////////////////////////////////////////////////////////
    // Upstream model
    ////////////////////////////////////////////////////////////////////

    initial begin
        forever begin
            @(negedge clk);
            if (!rst && job_fetch_request) begin
                wait_cycles(rand_range(1, 4) - 1);
                job_fetch_ack = 1'b1;
                @(negedge clk);
                job_fetch_ack = 1'b0;
                wait_cycles(rand_range(1, 4));
                job_fetch_complete = 1'b1;
                @(negedge clk);
                job_fetch_complete = 1'b0;
            end
        end
    end

    initial begin
        forever begin
            @(negedge clk);
            pipeline_flushed = rand_range(0, 1) == 1;
            if (!rst && job_complete) begin
                wait_cycles(rand_range(1, 4) - 1);
                job_complete_ack = 1'b1;
                @(negedge clk);
                job_complete_ack = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            report_error("Timeout: jobs did not finish within the cycle limit");
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////

    initial begin
        rst                     = 1'b1;
        num_expd_input_cols     = '1;
        num_expd_input_rows     = '0;
        num_output_cols         = row_col_t'(1);
        pfb_full_count          = '0;
        pix_seq_data_full_count = '0;
        num_kernels             = '0;
        job_start               = 1'b0;
        job_fetch_ack           = 1'b0;
        job_fetch_complete      = 1'b0;
        job_complete_ack        = 1'b0;
        pipeline_flushed        = 1'b0;

        // Draw all jobs first so the timeout can cover them
        for (int j = 0; j < NUM_JOBS; j++) begin
            job_rows[j] = rand_range(2, 5);
            job_pfb[j]  = rand_range(1, 12);
            job_seq[j]  = rand_range(1, 40);
            job_cols[j] = rand_range(1, 3);
            job_nk[j]   = rand_range(0, 4);
            cycle_limit += 2 * ((job_rows[j] + 1) * (job_pfb[j] + 16)
                              + (job_rows[j] - 1) * (job_seq[j] + 6) + 40);
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int j = 0; j < NUM_JOBS; j++) begin
            // One pfb read per expanded input column
            num_expd_input_cols     = row_col_t'(job_pfb[j]);
            num_expd_input_rows     = row_col_t'(job_rows[j]);
            pfb_full_count          = pfb_count_t'(job_pfb[j]);
            pix_seq_data_full_count = seq_addr_t'(job_seq[j]);
            num_output_cols         = row_col_t'(job_cols[j]);
            num_kernels             = kernel_grp_t'(job_nk[j]);
            job_start               = 1'b1;
            do @(negedge clk); while (!job_accept);
            job_start = 1'b0;
            do @(negedge clk); while (!job_complete);
            do @(negedge clk); while (job_complete);
        end

        wait_cycles(12);
        if (!failed) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== rtl/ce_issue_chain.sv ====
module ce_issue_chain (
    input  logic                       clk,
    input  logic                       rst,
    input  quad_ctrl_pkg::kernel_grp_t num_kernels,
    output quad_ctrl_pkg::ce_vec_t     ce_execute,
    output quad_ctrl_pkg::ce_vec_t     next_kernel,
    output logic                       ctrl_last_kernel,
    window_pass_if.monitor             wp
);
    import quad_ctrl_pkg::*;

    // Read strobe in flight through the sequence BRAM
    logic [SEQ_RD_LATENCY-2:0] rd_dly;
    kernel_grp_t               kernel_grp;
    kernel_grp_t               kernel_grp_nxt;

    //////////////////////////////////////////////////////////////////////
    // Execute and next-kernel chains
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_dly      <= '0;
            ce_execute  <= '0;
            next_kernel <= '0;
        end else begin
            rd_dly[0] <= wp.seq_rden;
            for (int i = 1; i < SEQ_RD_LATENCY - 1; i++) begin
                rd_dly[i] <= rd_dly[i-1];
            end

            // last stage of the read latency lands on CE 0
            ce_execute[0]  <= rd_dly[SEQ_RD_LATENCY-2];
            next_kernel[0] <= wp.window_end && wp.last_col;
            for (int i = 1; i < NUM_CE; i++) begin
                ce_execute[i]  <= ce_execute[i-1];
                next_kernel[i] <= next_kernel[i-1];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Kernel groups
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        kernel_grp_nxt = kernel_grp;
        if (wp.window_end) begin
            kernel_grp_nxt = (kernel_grp == num_kernels) ? '0 : kernel_grp + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            kernel_grp       <= '0;
            ctrl_last_kernel <= 1'b0;
        end else begin
            kernel_grp       <= kernel_grp_nxt;
            ctrl_last_kernel <= (kernel_grp_nxt == num_kernels);
        end
    end

endmodule

// ==== rtl/job_ctrl_fsm.sv ====
module job_ctrl_fsm (
    input  logic           clk,
    input  logic           rst,
    input  logic           job_start,
    input  logic           job_fetch_ack,
    input  logic           job_fetch_complete,
    input  logic           pipeline_flushed,
    input  logic           job_complete_ack,
    output logic           job_accept,
    output logic           job_fetch_request,
    output logic           job_fetch_in_progress,
    output logic           job_complete,
    row_fetch_if.fsm       rf,
    window_pass_if.fsm     wp
);
    import quad_ctrl_pkg::*;

    job_state_e state;
    logic       priming;

    // Still filling the first rows of the buffer
    assign priming = rf.rows_left && (rf.input_row < row_col_t'(PRIME_ROWS));

    always_ff @(posedge clk) begin
        if (rst) begin
            state                 <= ST_IDLE;
            job_accept            <= 1'b0;
            job_fetch_request     <= 1'b0;
            job_fetch_in_progress <= 1'b0;
            job_complete          <= 1'b0;
            rf.load_row           <= 1'b0;
            wp.pass_start         <= 1'b0;
        end else begin
            // Pulses
            job_accept    <= 1'b0;
            rf.load_row   <= 1'b0;
            wp.pass_start <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (job_start) begin
                        job_accept <= 1'b1;
                        // first row of a job is always fetched
                        state      <= ST_FETCH_ROW;
                    end
                end

                // Decision point after every row read
                ST_PRIME: begin
                    if (priming) begin
                        state <= ST_FETCH_ROW;
                    end else begin
                        wp.pass_start <= 1'b1;
                        state         <= ST_ACTIVE;
                    end
                end

                ST_FETCH_ROW: begin
                    if (job_fetch_in_progress && job_fetch_complete) begin
                        job_fetch_in_progress <= 1'b0;
                        rf.load_row           <= 1'b1;
                        state                 <= ST_READ_ROW;
                    end else if (job_fetch_request && job_fetch_ack) begin
                        job_fetch_request     <= 1'b0;
                        job_fetch_in_progress <= 1'b1;
                    end else if (!job_fetch_in_progress) begin
                        job_fetch_request     <= 1'b1;
                    end
                end

                ST_READ_ROW: begin
                    if (rf.row_done) begin
                        state <= ST_PRIME;
                    end
                end

                // Next row loads between passes
                ST_ACTIVE: begin
                    if (wp.pass_done) begin
                        state <= rf.rows_left ? ST_FETCH_ROW : ST_WAIT_FLUSH;
                    end
                end

                ST_WAIT_FLUSH: begin
                    if (pipeline_flushed) begin
                        job_complete <= 1'b1;
                        state        <= ST_SEND_COMPLETE;
                    end
                end

                ST_SEND_COMPLETE: begin
                    if (job_complete_ack) begin
                        job_complete <= 1'b0;
                        state        <= ST_IDLE;
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    a_fetch_phases: assert property (@(posedge clk) disable iff (rst)
        !(job_fetch_request && job_fetch_in_progress))
        else $error("fetch request still high during fetch in progress");

endmodule

// ==== rtl/pfb_row_reader.sv ====
module pfb_row_reader (
    input  logic                      clk,
    input  logic                      rst,
    input  quad_ctrl_pkg::pfb_count_t pfb_full_count,
    input  logic                      job_fetch_complete,
    input  logic                      job_fetch_in_progress,
    input  quad_ctrl_pkg::row_col_t   num_expd_input_rows,
    output logic                      pfb_rden,
    output quad_ctrl_pkg::row_col_t   input_col,
    row_fetch_if.reader               rf
);
    import quad_ctrl_pkg::*;

    pfb_count_t pfb_count;
    logic       fetch_done;
    logic       row_end;
    logic       rows_exhausted;

    assign fetch_done   = job_fetch_complete && job_fetch_in_progress;
    // Last strobe of a row, or an empty row
    assign row_end      = (pfb_rden && pfb_count == pfb_count_t'(1))
                        || (rf.load_row && pfb_count == '0);
    assign rf.rows_left = (rf.input_row <= num_expd_input_rows);

    //////////////////////////////////////////////////////////////////////
    // Fill count and read strobes
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pfb_count   <= '0;
            pfb_rden    <= 1'b0;
            rf.row_done <= 1'b0;
        end else begin
            if (fetch_done) begin
                pfb_count <= pfb_full_count;
            end else if (pfb_rden) begin
                pfb_count <= pfb_count - 1'b1;
            end

            if (rf.load_row) begin
                pfb_rden <= (pfb_count != '0);
            end else if (pfb_rden) begin
                pfb_rden <= !row_end;
            end

            rf.row_done <= row_end;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Row and column position
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            input_col      <= '0;
            rf.input_row   <= '0;
            rows_exhausted <= 1'b0;
        end else begin
            if (rf.load_row) begin
                input_col <= '0;
            end else if (pfb_rden) begin
                input_col <= input_col + 1'b1;
            end

            // New job starts counting rows again
            if (fetch_done && rows_exhausted) begin
                rf.input_row   <= '0;
                rows_exhausted <= 1'b0;
            end else if (row_end) begin
                rf.input_row   <= rf.input_row + 1'b1;
                rows_exhausted <= (rf.input_row == num_expd_input_rows);
            end
        end
    end

    a_rden_has_data: assert property (@(posedge clk) disable iff (rst)
        pfb_rden |-> pfb_count != '0)
        else $error("pfb read issued with an empty fill count");

endmodule

// ==== rtl/pix_seq_reader.sv ====
module pix_seq_reader (
    input  logic                     clk,
    input  logic                     rst,
    input  quad_ctrl_pkg::seq_addr_t pix_seq_data_full_count,
    input  quad_ctrl_pkg::row_col_t  num_output_cols,
    output logic                     pix_seq_bram_rden,
    output quad_ctrl_pkg::seq_addr_t pix_seq_bram_rdaddr,
    output quad_ctrl_pkg::win_cyc_t  cycle_counter,
    output quad_ctrl_pkg::gray_t     gray_code,
    window_pass_if.reader            wp
);
    import quad_ctrl_pkg::*;

    seq_addr_t reads_left;
    row_col_t  output_col;
    gray_t     pass_cnt;
    logic      last_read;

    assign last_read     = pix_seq_bram_rden && (reads_left == seq_addr_t'(1));
    assign wp.seq_rden   = pix_seq_bram_rden;
    assign wp.window_end = pix_seq_bram_rden
                         && (cycle_counter == win_cyc_t'(WINDOW_CYCLES - 1));
    assign wp.last_col   = (output_col == num_output_cols - 1'b1);
    // binary pass count to gray
    assign gray_code     = {pass_cnt[1], ^pass_cnt};

    always_ff @(posedge clk) begin
        if (rst) begin
            reads_left          <= '0;
            pix_seq_bram_rden   <= 1'b0;
            pix_seq_bram_rdaddr <= '0;
            cycle_counter       <= '0;
            output_col          <= '0;
            wp.pass_done        <= 1'b0;
            pass_cnt            <= '0;
        end else begin
            wp.pass_done <= last_read
                         || (wp.pass_start && pix_seq_data_full_count == '0);

            if (wp.pass_start) begin
                reads_left          <= pix_seq_data_full_count;
                pix_seq_bram_rden   <= (pix_seq_data_full_count != '0);
                pix_seq_bram_rdaddr <= '0;
                cycle_counter       <= '0;
                output_col          <= '0;
            end else if (pix_seq_bram_rden) begin
                reads_left          <= reads_left - 1'b1;
                pix_seq_bram_rden   <= !last_read;
                pix_seq_bram_rdaddr <= pix_seq_bram_rdaddr + 1'b1;
                if (wp.window_end) begin
                    cycle_counter <= '0;
                    output_col    <= wp.last_col ? '0 : output_col + 1'b1;
                end else begin
                    cycle_counter <= cycle_counter + 1'b1;
                end
            end

            if (wp.pass_done) begin
                pass_cnt <= pass_cnt + 1'b1;
            end
        end
    end

    a_window_range: assert property (@(posedge clk) disable iff (rst)
        cycle_counter < win_cyc_t'(WINDOW_CYCLES))
        else $error("window cycle counter out of range");

endmodule

// ==== rtl/quad_bram_ctrl.sv ====
module quad_bram_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    // Job geometry
    input  quad_ctrl_pkg::row_col_t    num_expd_input_cols,
    input  quad_ctrl_pkg::row_col_t    num_expd_input_rows,
    input  quad_ctrl_pkg::row_col_t    num_output_cols,
    input  quad_ctrl_pkg::pfb_count_t  pfb_full_count,
    input  quad_ctrl_pkg::seq_addr_t   pix_seq_data_full_count,
    input  quad_ctrl_pkg::kernel_grp_t num_kernels,
    // Job handshakes
    input  logic                       job_start,
    output logic                       job_accept,
    output logic                       job_fetch_request,
    output logic                       job_fetch_in_progress,
    input  logic                       job_fetch_ack,
    input  logic                       job_fetch_complete,
    output logic                       job_complete,
    input  logic                       job_complete_ack,
    input  logic                       pipeline_flushed,
    // Prefetch buffer
    output logic                       pfb_rden,
    output quad_ctrl_pkg::row_col_t    input_col,
    // Pixel sequence BRAM
    output logic                       pix_seq_bram_rden,
    output quad_ctrl_pkg::seq_addr_t   pix_seq_bram_rdaddr,
    output quad_ctrl_pkg::win_cyc_t    cycle_counter,
    output quad_ctrl_pkg::gray_t       gray_code,
    // CE issue
    output quad_ctrl_pkg::ce_vec_t     ce_execute,
    output quad_ctrl_pkg::ce_vec_t     next_kernel,
    output logic                       ctrl_last_kernel
);

    row_fetch_if   rf ();
    window_pass_if wp ();

    job_ctrl_fsm u_fsm (
        .clk                   (clk),
        .rst                   (rst),
        .job_start             (job_start),
        .job_fetch_ack         (job_fetch_ack),
        .job_fetch_complete    (job_fetch_complete),
        .pipeline_flushed      (pipeline_flushed),
        .job_complete_ack      (job_complete_ack),
        .job_accept            (job_accept),
        .job_fetch_request     (job_fetch_request),
        .job_fetch_in_progress (job_fetch_in_progress),
        .job_complete          (job_complete),
        .rf                    (rf),
        .wp                    (wp)
    );

    pfb_row_reader u_pfb (
        .clk                   (clk),
        .rst                   (rst),
        .pfb_full_count        (pfb_full_count),
        .job_fetch_complete    (job_fetch_complete),
        .job_fetch_in_progress (job_fetch_in_progress),
        .num_expd_input_rows   (num_expd_input_rows),
        .pfb_rden              (pfb_rden),
        .input_col             (input_col),
        .rf                    (rf)
    );

    // Row length comes from the pfb count; it must fit the expanded width
    a_col_in_row: assert property (@(posedge clk) disable iff (rst)
        pfb_rden |-> input_col < num_expd_input_cols)
        else $error("pfb read past the last expanded input column");

    pix_seq_reader u_seq (
        .clk                     (clk),
        .rst                     (rst),
        .pix_seq_data_full_count (pix_seq_data_full_count),
        .num_output_cols         (num_output_cols),
        .pix_seq_bram_rden       (pix_seq_bram_rden),
        .pix_seq_bram_rdaddr     (pix_seq_bram_rdaddr),
        .cycle_counter           (cycle_counter),
        .gray_code               (gray_code),
        .wp                      (wp)
    );

    ce_issue_chain u_ce (
        .clk              (clk),
        .rst              (rst),
        .num_kernels      (num_kernels),
        .ce_execute       (ce_execute),
        .next_kernel      (next_kernel),
        .ctrl_last_kernel (ctrl_last_kernel),
        .wp               (wp)
    );

endmodule

// ==== rtl/quad_ctrl_pkg.sv ====
package quad_ctrl_pkg;

    //////////////////////////////////////////////////////////////////////
    // Quad geometry
    //////////////////////////////////////////////////////////////////////

    localparam int ROW_BUF_DEPTH_LOG2 = 10;
    localparam int NUM_AWE            = 4;
    localparam int CE_PER_AWE         = 2;
    localparam int NUM_CE             = NUM_AWE * CE_PER_AWE;

    // 3x3 window, one pixel per read
    localparam int WINDOW_CYCLES      = 9;
    localparam int SEQ_RD_LATENCY     = 3;
    localparam int PRIME_ROWS         = 3;
    localparam int KERNEL_GRP_W       = 5;

    //////////////////////////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////////////////////////

    typedef logic [ROW_BUF_DEPTH_LOG2-1:0] row_col_t;
    typedef logic [9:0]                    pfb_count_t;
    typedef logic [11:0]                   seq_addr_t;
    typedef logic [3:0]                    win_cyc_t;
    typedef logic [KERNEL_GRP_W-1:0]       kernel_grp_t;
    typedef logic [NUM_CE-1:0]             ce_vec_t;
    typedef logic [1:0]                    gray_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PRIME,
        ST_FETCH_ROW,
        ST_READ_ROW,
        ST_ACTIVE,
        ST_WAIT_FLUSH,
        ST_SEND_COMPLETE
    } job_state_e;

endpackage

// ==== rtl/row_fetch_if.sv ====
interface row_fetch_if;
    import quad_ctrl_pkg::*;

    logic     load_row;
    logic     row_done;
    row_col_t input_row;
    logic     rows_left;

    modport fsm (
        output load_row,
        input  row_done,
        input  input_row,
        input  rows_left
    );

    modport reader (
        input  load_row,
        output row_done,
        output input_row,
        output rows_left
    );

endinterface

// ==== rtl/window_pass_if.sv ====
interface window_pass_if;

    logic pass_start;
    logic pass_done;
    logic seq_rden;
    logic window_end;
    logic last_col;

    modport fsm (
        output pass_start,
        input  pass_done
    );

    modport reader (
        input  pass_start,
        output pass_done,
        output seq_rden,
        output window_end,
        output last_col
    );

    // CE side only watches the read stream
    modport monitor (
        input  pass_start,
        input  pass_done,
        input  seq_rden,
        input  window_end,
        input  last_col
    );

endinterface
